/* include/gcu_macros.svh */
// widths, video RAM region bounds and register select codes
// beam positions for sync, blanking and the vertical interrupt

`ifndef GCU_MACROS_SVH
`define GCU_MACROS_SVH

// bus and memory widths
`define GCU_DATA_W        16
`define GCU_ADDR_W        13
`define GCU_LAYER_ADDR_W  11
`define GCU_BEAM_W        9

// video RAM regions, each layer copy covers [base, next base)
`define GCU_SCROLL0_BASE  13'h0000
`define GCU_SCROLL1_BASE  13'h0800
`define GCU_SCROLL2_BASE  13'h1000
`define GCU_SPRITE_BASE   13'h1800
`define GCU_SPRITE_END    13'h1C00

// register select decode
`define GCU_REG_INDEX_MASK  8'h8F
`define GCU_REG_VINT_ACK_A  8'h0E
`define GCU_REG_VINT_ACK_B  8'h0F

// beam positions, sync ranges are inclusive
`define GCU_HSYNC_START   9'd326
`define GCU_HSYNC_END     9'd379
`define GCU_VSYNC_START   9'd232
`define GCU_VSYNC_END     9'd245
`define GCU_VINT_LINE     9'd230

`endif

/* verilog/gcu_pkg.sv */
// bus word union, CPU operation struct and video RAM write struct
// renderer layer read structs and the scroll register block

`include "gcu_macros.svh"

package gcu_pkg;

    // one CPU data word, read either as plain data or as a register select
    typedef union packed {
        logic [`GCU_DATA_W-1:0] raw;
        struct packed {
            logic [7:0] unused_hi;
            logic       mirror;
            logic [2:0] unused_mid;
            logic [3:0] index;
        } sel;
    } gcu_bus_word_u;

    // at most one bit set, held by the CPU until ack
    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic set_ptr;
        logic write_ram;
        logic read_h;
        logic read_l;
    } gcu_op_t;

    typedef struct packed {
        logic [`GCU_ADDR_W-1:0] addr;
        logic [`GCU_DATA_W-1:0] data;
        logic                   we;
    } gcu_vram_wr_t;

    // renderer read addresses, one per layer copy
    typedef struct packed {
        logic [`GCU_LAYER_ADDR_W-1:0] scroll0;
        logic [`GCU_LAYER_ADDR_W-1:0] scroll1;
        logic [`GCU_LAYER_ADDR_W-1:0] scroll2;
        logic [`GCU_LAYER_ADDR_W-1:0] sprite;
    } gcu_layer_addr_t;

    typedef struct packed {
        logic [`GCU_DATA_W-1:0] scroll0;
        logic [`GCU_DATA_W-1:0] scroll1;
        logic [`GCU_DATA_W-1:0] scroll2;
        logic [`GCU_DATA_W-1:0] sprite;
    } gcu_layer_data_t;

    // scroll positions in register index order, bg_x is index 0
    typedef struct packed {
        logic [`GCU_DATA_W-1:0] bg_x;
        logic [`GCU_DATA_W-1:0] bg_y;
        logic [`GCU_DATA_W-1:0] fg_x;
        logic [`GCU_DATA_W-1:0] fg_y;
        logic [`GCU_DATA_W-1:0] text_x;
        logic [`GCU_DATA_W-1:0] text_y;
        logic [`GCU_DATA_W-1:0] sprite_x;
        logic [`GCU_DATA_W-1:0] sprite_y;
    } gcu_scroll_t;

endpackage

/* verilog/gcu_bus_port.sv */
// CPU operation sequencer with the video RAM pointer
// write and read cycles, ack and dout

`timescale 1ns/1ns

`include "gcu_macros.svh"

module gcu_bus_port (
    input  logic                    CLK96,
    input  logic                    RESET96,
    input  gcu_pkg::gcu_op_t        op,
    input  gcu_pkg::gcu_bus_word_u  din,
    input  logic [`GCU_DATA_W-1:0]  rd_data,
    output logic                    ack,
    output logic [`GCU_DATA_W-1:0]  dout,
    output logic                    sel_strobe,
    output logic                    wr_strobe,
    output gcu_pkg::gcu_vram_wr_t   vram_wr,
    output logic [`GCU_ADDR_W-1:0]  rd_addr
);
    import gcu_pkg::*;

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_wr      = 2'd1;
    localparam logic [1:0] st_rd_wait = 2'd2;
    localparam logic [1:0] st_rd_load = 2'd3;

    gcu_op_t                op_q;
    logic [1:0]             state_q;
    logic [`GCU_DATA_W-1:0] ptr_q;
    logic [`GCU_ADDR_W-1:0] wr_addr_q;
    logic [`GCU_DATA_W-1:0] wr_data_q;
    logic                   we_q;
    logic                   go;
    logic                   go_read;

    // an operation starts when op differs from last cycle's op
    assign go      = (op != op_q) && (state_q == st_idle);
    assign go_read = go && (op.read_h || op.read_l);

    // register side needs only a single-cycle pulse
    assign sel_strobe = go && op.select_reg;
    assign wr_strobe  = go && op.write_reg;

    assign vram_wr = '{addr: wr_addr_q, data: wr_data_q, we: we_q};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            op_q    <= '0;
            state_q <= st_idle;
            ptr_q   <= '0;
            we_q    <= 1'b0;
            ack     <= 1'b1;
        end else begin
            op_q <= op;
            case (state_q)
                st_idle: begin
                    if (go && op.set_ptr) begin
                        ptr_q <= din.raw;
                    end
                    if (go && op.write_ram) begin
                        we_q    <= 1'b1;
                        ack     <= 1'b0;
                        state_q <= st_wr;
                    end
                    if (go_read) begin
                        ack     <= 1'b0;
                        state_q <= st_rd_wait;
                    end
                end
                st_wr: begin
                    // write lands this edge, step the pointer
                    we_q    <= 1'b0;
                    ptr_q   <= ptr_q + 1'b1;
                    ack     <= 1'b1;
                    state_q <= st_idle;
                end
                st_rd_wait: begin
                    // RAM output registers on this edge
                    state_q <= st_rd_load;
                end
                default: begin
                    ack     <= 1'b1;
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge CLK96) begin
        if (go && op.write_ram) begin
            wr_addr_q <= ptr_q[`GCU_ADDR_W-1:0];
            wr_data_q <= din.raw;
        end
        if (go_read) begin
            // low word sits one above the pointer, wraps within 8K
            rd_addr <= ptr_q[`GCU_ADDR_W-1:0] + `GCU_ADDR_W'(op.read_l);
        end
        if (state_q == st_rd_load) begin
            dout <= rd_data;
        end
    end

    // any RAM cycle hands ack back within three cycles
    ack_bounded: assert property (@(posedge CLK96) disable iff (RESET96)
        $fell(ack) |-> ##[1:3] ack);

endmodule

/* verilog/gcu_scroll_regs.sv */
// register select latch and the eight scroll registers
// interrupt clear decode from the selected register

`timescale 1ns/1ns

`include "gcu_macros.svh"

module gcu_scroll_regs (
    input  logic                    CLK96,
    input  logic                    RESET96,
    input  logic                    sel_strobe,
    input  logic                    wr_strobe,
    input  gcu_pkg::gcu_bus_word_u  din,
    output gcu_pkg::gcu_scroll_t    scroll,
    output logic                    vint_clear
);
    import gcu_pkg::*;

    gcu_bus_word_u sel_q;
    gcu_scroll_t   scroll_q;
    logic [7:0]    sel_code;

    assign sel_code = sel_q.raw[7:0];
    assign scroll   = scroll_q;

    // 0x0E, 0x0F and mirrored 0x0F hold the interrupt clear
    assign vint_clear = (sel_code == `GCU_REG_VINT_ACK_A) ||
                        (sel_code == `GCU_REG_VINT_ACK_B) ||
                        (sel_code == (`GCU_REG_VINT_ACK_B | 8'h80));

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            // 0xFF selects nothing and clears nothing
            sel_q.raw <= 16'h00FF;
        end else if (sel_strobe) begin
            sel_q.raw <= {8'h00, din.raw[7:0] & `GCU_REG_INDEX_MASK};
        end
    end

    // mirror flag does not matter, index bit 3 set is ignored
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            scroll_q <= '0;
        end else if (wr_strobe && !sel_q.sel.index[3]) begin
            case (sel_q.sel.index[2:0])
                3'd0: begin
                    scroll_q.bg_x <= din.raw;
                end
                3'd1: begin
                    scroll_q.bg_y <= din.raw;
                end
                3'd2: begin
                    scroll_q.fg_x <= din.raw;
                end
                3'd3: begin
                    scroll_q.fg_y <= din.raw;
                end
                3'd4: begin
                    scroll_q.text_x <= din.raw;
                end
                3'd5: begin
                    scroll_q.text_y <= din.raw;
                end
                3'd6: begin
                    scroll_q.sprite_x <= din.raw;
                end
                default: begin
                    scroll_q.sprite_y <= din.raw;
                end
            endcase
        end
    end

    // bus port issues one operation at a time
    strobes_exclusive: assert property (@(posedge CLK96) disable iff (RESET96)
        !(sel_strobe && wr_strobe));

endmodule

/* verilog/gcu_vram.sv */
// main 8K video RAM with CPU read port
// four 2K layer copies split by address region, renderer read ports

`timescale 1ns/1ns

`include "gcu_macros.svh"

module gcu_vram (
    input  logic                          CLK96,
    input  gcu_pkg::gcu_vram_wr_t         vram_wr,
    input  logic [`GCU_ADDR_W-1:0]        rd_addr,
    input  gcu_pkg::gcu_layer_addr_t      layer_addr,
    output logic [`GCU_DATA_W-1:0]        rd_data,
    output gcu_pkg::gcu_layer_data_t      layer_data
);

    // layer n owns [region_bound[n], region_bound[n+1])
    localparam logic [`GCU_ADDR_W-1:0] region_bound [5] = '{
        `GCU_SCROLL0_BASE,
        `GCU_SCROLL1_BASE,
        `GCU_SCROLL2_BASE,
        `GCU_SPRITE_BASE,
        `GCU_SPRITE_END
    };

    logic [`GCU_DATA_W-1:0]       main_mem [0:(1<<`GCU_ADDR_W)-1];
    logic [`GCU_LAYER_ADDR_W-1:0] lay_raddr [4];
    logic [`GCU_DATA_W-1:0]       lay_rdata [4];
    logic [3:0]                   lay_we;

    always_ff @(posedge CLK96) begin
        if (vram_wr.we) begin
            main_mem[vram_wr.addr] <= vram_wr.data;
        end
        rd_data <= main_mem[rd_addr];
    end

    // layer order 0..3 is scroll0, scroll1, scroll2, sprite
    assign lay_raddr[0] = layer_addr.scroll0;
    assign lay_raddr[1] = layer_addr.scroll1;
    assign lay_raddr[2] = layer_addr.scroll2;
    assign lay_raddr[3] = layer_addr.sprite;

    assign layer_data = '{
        scroll0: lay_rdata[0],
        scroll1: lay_rdata[1],
        scroll2: lay_rdata[2],
        sprite:  lay_rdata[3]
    };

    for (genvar g = 0; g < 4; g++) begin : g_layer
        logic [`GCU_DATA_W-1:0] mem [0:(1<<`GCU_LAYER_ADDR_W)-1];
        logic [`GCU_DATA_W-1:0] rdata_q;

        assign lay_we[g] = vram_wr.we &&
                           (vram_wr.addr >= region_bound[g]) &&
                           (vram_wr.addr < region_bound[g+1]);

        always_ff @(posedge CLK96) begin
            if (lay_we[g]) begin
                mem[vram_wr.addr[`GCU_LAYER_ADDR_W-1:0]] <= vram_wr.data;
            end
            rdata_q <= mem[lay_raddr[g]];
        end

        assign lay_rdata[g] = rdata_q;
    end

    // regions do not overlap
    one_layer_write: assert property (@(posedge CLK96) $onehot0(lay_we));

endmodule

/* verilog/gcu_video_timing.sv */
// sync and blanking decode from the beam counters
// active-low vertical interrupt level

`timescale 1ns/1ns

`include "gcu_macros.svh"

module gcu_video_timing (
    input  logic [`GCU_BEAM_W-1:0] v,
    input  logic [`GCU_BEAM_W-1:0] h,
    input  logic                   vint_clear,
    input  logic                   RESET96,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   fblank,
    output logic                   vint
);

    // syncs low over inclusive ranges
    assign hsync = !((h >= `GCU_HSYNC_START) && (h <= `GCU_HSYNC_END));
    assign vsync = !((v >= `GCU_VSYNC_START) && (v <= `GCU_VSYNC_END));

    // blank whenever either sync is active
    assign fblank = hsync && vsync;

    // held low on the interrupt line, while cleared, and through reset
    assign vint = !((v == `GCU_VINT_LINE) || vint_clear || RESET96);

endmodule

/* verilog/gcu_top.sv */
// graphics controller top level, CPU side
// wires the bus port, scroll registers, video RAM and video timing

`timescale 1ns/1ns

`include "gcu_macros.svh"

module gcu_top (
    input  logic                      CLK96,
    input  logic                      RESET96,
    input  gcu_pkg::gcu_op_t          op,
    input  gcu_pkg::gcu_bus_word_u    din,
    output logic                      ack,
    output logic [`GCU_DATA_W-1:0]    dout,
    input  logic [`GCU_BEAM_W-1:0]    v,
    input  logic [`GCU_BEAM_W-1:0]    h,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      fblank,
    output logic                      vint,
    output gcu_pkg::gcu_scroll_t      scroll,
    input  gcu_pkg::gcu_layer_addr_t  layer_addr,
    output gcu_pkg::gcu_layer_data_t  layer_data
);
    import gcu_pkg::*;

    logic                   sel_strobe;
    logic                   wr_strobe;
    gcu_vram_wr_t           vram_wr;
    logic [`GCU_ADDR_W-1:0] rd_addr;
    logic [`GCU_DATA_W-1:0] rd_data;
    logic                   vint_clear;

    gcu_bus_port u_bus_port (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .op         (op),
        .din        (din),
        .rd_data    (rd_data),
        .ack        (ack),
        .dout       (dout),
        .sel_strobe (sel_strobe),
        .wr_strobe  (wr_strobe),
        .vram_wr    (vram_wr),
        .rd_addr    (rd_addr)
    );

    gcu_scroll_regs u_scroll_regs (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .sel_strobe (sel_strobe),
        .wr_strobe  (wr_strobe),
        .din        (din),
        .scroll     (scroll),
        .vint_clear (vint_clear)
    );

    gcu_vram u_vram (
        .CLK96      (CLK96),
        .vram_wr    (vram_wr),
        .rd_addr    (rd_addr),
        .layer_addr (layer_addr),
        .rd_data    (rd_data),
        .layer_data (layer_data)
    );

    gcu_video_timing u_video_timing (
        .v          (v),
        .h          (h),
        .vint_clear (vint_clear),
        .RESET96    (RESET96),
        .hsync      (hsync),
        .vsync      (vsync),
        .fblank     (fblank),
        .vint       (vint)
    );

endmodule

/* sim/gcu_tb.sv */
// directed testbench for the graphics controller CPU side
// clock, reset, watchdog, RAM and pointer model, tests and summary

`timescale 1ns/1ns

`include "gcu_macros.svh"

module gcu_tb;
    import gcu_pkg::*;

    // rough cycle cost of each test in run order
    localparam int budget_cycles = 20 + 200 + 300 + 100 + 40 + 60;
    localparam int watchdog_ns   = budget_cycles * 2 * 40;

    logic                   CLK96;
    logic                   RESET96;
    gcu_op_t                op;
    gcu_bus_word_u          din;
    logic                   ack;
    logic [`GCU_DATA_W-1:0] dout;
    logic [`GCU_BEAM_W-1:0] v;
    logic [`GCU_BEAM_W-1:0] h;
    logic                   hsync;
    logic                   vsync;
    logic                   fblank;
    logic                   vint;
    gcu_scroll_t            scroll;
    gcu_layer_addr_t        layer_addr;
    gcu_layer_data_t        layer_data;

    // model of the video RAM and the pointer
    logic [15:0] ref_mem [0:8191];
    logic [15:0] ref_ptr;
    logic [15:0] scroll_exp [8];
    string       field_names [8] = '{"bg_x", "bg_y", "fg_x", "fg_y",
                                     "text_x", "text_y", "sprite_x", "sprite_y"};
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    gcu_top dut_i (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .op         (op),
        .din        (din),
        .ack        (ack),
        .dout       (dout),
        .v          (v),
        .h          (h),
        .hsync      (hsync),
        .vsync      (vsync),
        .fblank     (fblank),
        .vint       (vint),
        .scroll     (scroll),
        .layer_addr (layer_addr),
        .layer_data (layer_data)
    );

    initial begin
        CLK96 = 1'b0;
        forever #20 CLK96 = ~CLK96;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, tests did not finish", watchdog_ns);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic end_test(input string name, input int start);
        tests_run++;
        if (errors > start) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - start);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // drive one operation, wait for ack, then go back to idle
    task automatic run_op(input gcu_op_t o, input logic [15:0] d);
        int waited;
        waited = 0;
        @(posedge CLK96);
        #2;
        op = o;
        din.raw = d;
        @(posedge CLK96);
        #2;
        while (!ack && waited < 6) begin
            @(posedge CLK96);
            #2;
            waited++;
        end
        if (!ack) begin
            $display("ack did not return high within 6 cycles at %0t ns", $time);
            errors++;
        end
        op = '0;
    endtask

    task automatic select_reg(input logic [7:0] code);
        gcu_op_t o;
        o = '0;
        o.select_reg = 1'b1;
        run_op(o, {8'h00, code});
    endtask

    task automatic write_reg(input logic [15:0] d);
        gcu_op_t o;
        o = '0;
        o.write_reg = 1'b1;
        run_op(o, d);
    endtask

    task automatic set_pointer(input logic [15:0] p);
        gcu_op_t o;
        o = '0;
        o.set_ptr = 1'b1;
        ref_ptr = p;
        run_op(o, p);
    endtask

    task automatic write_word(input logic [15:0] d);
        gcu_op_t o;
        o = '0;
        o.write_ram = 1'b1;
        ref_mem[ref_ptr[12:0]] = d;
        ref_ptr = ref_ptr + 16'd1;
        run_op(o, d);
    endtask

    // high word at the pointer, low word one above, both modulo 8K
    task automatic read_word(input logic low);
        gcu_op_t     o;
        logic [15:0] exp;
        o = '0;
        o.read_h = !low;
        o.read_l = low;
        exp = ref_mem[13'(ref_ptr[12:0] + {12'd0, low})];
        run_op(o, 16'h0000);
        if (dout !== exp) report_mismatch(low ? "dout (read_l)" : "dout (read_h)", dout, exp);
    endtask

    function automatic logic [15:0] field_of(input int idx);
        return scroll[(7 - idx) * 16 +: 16];
    endfunction

    task automatic compare_scroll();
        for (int i = 0; i < 8; i++) begin
            if (field_of(i) !== scroll_exp[i]) begin
                report_mismatch({"scroll.", field_names[i]}, field_of(i), scroll_exp[i]);
            end
        end
    endtask

    task automatic reset_state();
        int start;
        start = errors;
        repeat (4) @(posedge CLK96);
        #2;
        if (vint !== 1'b0) report_mismatch("vint", vint, 1'b0);
        if (ack !== 1'b1) report_mismatch("ack", ack, 1'b1);
        repeat (4) @(posedge CLK96);
        #2;
        RESET96 = 1'b0;
        #2;
        for (int i = 0; i < 8; i++) scroll_exp[i] = 16'h0000;
        compare_scroll();
        // select latch comes out of reset on a non-clearing code
        if (vint !== 1'b1) report_mismatch("vint", vint, 1'b1);
        end_test("reset state", start);
    endtask

    task automatic scroll_writes();
        logic [15:0] d;
        int          start;
        start = errors;
        for (int i = 0; i < 8; i++) begin
            d = 16'($urandom);
            select_reg(8'(i));
            write_reg(d);
            scroll_exp[i] = d;
        end
        compare_scroll();
        // same registers with the mirror flag set
        for (int i = 0; i < 8; i++) begin
            d = 16'($urandom);
            select_reg(8'h80 | 8'(i));
            write_reg(d);
            scroll_exp[i] = d;
        end
        compare_scroll();
        select_reg(8'h0E);
        write_reg(16'($urandom));
        compare_scroll();
        end_test("scroll register writes", start);
    endtask

    task automatic pointer_access();
        logic [15:0] base;
        int          start;
        start = errors;
        base = 16'($urandom % 32'h1F00);
        set_pointer(base);
        for (int k = 0; k < 8; k++) write_word(16'($urandom));
        for (int k = 0; k < 7; k++) begin
            set_pointer(base + 16'(k));
            read_word(1'b0);
            read_word(1'b1);
        end
        // 0x3FFF lands on 0x1FFF and the next write wraps to 0x0000
        set_pointer(16'h3FFF);
        write_word(16'($urandom));
        write_word(16'($urandom));
        set_pointer(16'hFFFF);
        read_word(1'b0);
        read_word(1'b1);
        end_test("pointer writes and reads", start);
    endtask

    task automatic layer_split();
        logic [12:0] bases [4] = '{`GCU_SCROLL0_BASE, `GCU_SCROLL1_BASE,
                                   `GCU_SCROLL2_BASE, `GCU_SPRITE_BASE};
        int          sizes [4] = '{2048, 2048, 2048, 1024};
        logic [12:0] a;
        logic [15:0] d;
        int          start;
        start = errors;
        for (int r = 0; r < 4; r++) begin
            a = bases[r] + 13'($urandom % sizes[r]);
            d = 16'($urandom);
            set_pointer({3'b000, a});
            write_word(d);
            @(posedge CLK96);
            #2;
            layer_addr = '0;
            layer_addr[(3 - r) * 11 +: 11] = a[10:0];
            @(posedge CLK96);
            #2;
            if (layer_data[(3 - r) * 16 +: 16] !== d) begin
                report_mismatch($sformatf("layer_data[%0d]", r),
                                layer_data[(3 - r) * 16 +: 16], d);
            end
        end
        end_test("layer split", start);
    endtask

    task automatic set_beam(input int vv, input int hh);
        @(posedge CLK96);
        #2;
        v = 9'(vv);
        h = 9'(hh);
        #10;
    endtask

    task automatic sync_decode();
        int   h_pts [4] = '{325, 326, 379, 380};
        int   v_pts [4] = '{231, 232, 245, 246};
        // expected sync level at each sweep point
        logic h_lvl [4] = '{1'b1, 1'b0, 1'b0, 1'b1};
        logic v_lvl [4] = '{1'b1, 1'b0, 1'b0, 1'b1};
        logic ex_fb;
        int   start;
        start = errors;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                set_beam(v_pts[j], h_pts[i]);
                // blanked whenever either sync is low
                ex_fb = (h_lvl[i] == 1'b0 || v_lvl[j] == 1'b0) ? 1'b0 : 1'b1;
                if (hsync !== h_lvl[i]) report_mismatch("hsync", hsync, h_lvl[i]);
                if (vsync !== v_lvl[j]) report_mismatch("vsync", vsync, v_lvl[j]);
                if (fblank !== ex_fb) report_mismatch("fblank", fblank, ex_fb);
            end
        end
        end_test("sync and blank", start);
    endtask

    task automatic vint_level();
        logic [7:0] clear_codes [3] = '{8'h0E, 8'h0F, 8'h8F};
        int         start;
        start = errors;
        select_reg(8'h00);
        set_beam(229, 0);
        if (vint !== 1'b1) report_mismatch("vint", vint, 1'b1);
        set_beam(230, 0);
        if (vint !== 1'b0) report_mismatch("vint", vint, 1'b0);
        set_beam(229, 0);
        for (int i = 0; i < 3; i++) begin
            select_reg(clear_codes[i]);
            #5;
            if (vint !== 1'b0) report_mismatch("vint", vint, 1'b0);
            select_reg(8'h00);
            #5;
            if (vint !== 1'b1) report_mismatch("vint", vint, 1'b1);
        end
        end_test("vertical interrupt", start);
    endtask

    initial begin
        void'($urandom(56));
        RESET96 = 1'b1;
        op = '0;
        din = '0;
        v = '0;
        h = '0;
        layer_addr = '0;
        ref_ptr = '0;
        reset_state();
        scroll_writes();
        pointer_access();
        layer_split();
        sync_decode();
        vint_level();
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
verilog/gcu_pkg.sv
verilog/gcu_bus_port.sv
verilog/gcu_scroll_regs.sv
verilog/gcu_vram.sv
verilog/gcu_video_timing.sv
verilog/gcu_top.sv
sim/gcu_tb.sv

/* Bender.yml */
package:
  name: gcu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/gcu_pkg.sv
      - verilog/gcu_bus_port.sv
      - verilog/gcu_scroll_regs.sv
      - verilog/gcu_vram.sv
      - verilog/gcu_video_timing.sv
      - verilog/gcu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/gcu_tb.sv
